// File: design/thread_pkg.sv
// ==========================================================================
// Thread count and thread id definitions shared by every scheduler file
// Reached by scoped names such as thread_pkg::NTHREADS
// ==========================================================================

package thread_pkg;

	// Number of hardware threads in the barrel
	localparam int NTHREADS = 8;

	// Width of a thread id, enough to name every thread
	localparam int TID_W = 3;

	typedef logic [TID_W-1:0] tid_t;

	// The priority encoder always scans a 12-bit word
	// The upper bits stay zero with eight threads
	localparam int FFO_W = 12;

	// Encoder result for a word with no bit set
	localparam logic [3:0] FFO_NONE = 4'd15;

endpackage

// File: design/issue_pkg.sv
// ==========================================================================
// Program counter and credit definitions for the issue path
// ==========================================================================

package issue_pkg;

	// Program counter width and type
	localparam int PC_W = 32;

	typedef logic [PC_W-1:0] pc_t;

	// Width of the credit counter, wide enough to hold the full grant
	localparam int CREDIT_W = 3;

	// Credits the downstream pipeline grants at reset
	localparam logic [CREDIT_W-1:0] CREDITS = 3'd4;

endpackage

// File: design/find_first_one.sv
// ==========================================================================
// Priority encoder for the thread selector
// Reports the lowest set bit of a 12-bit word or the none code
// ==========================================================================
`timescale 1ns/100ps

module find_first_one (
	input  logic [thread_pkg::FFO_W-1:0] i,
	output logic [3:0]                   o
);

	// Scan from bit 0 upward and keep the first hit only
	always_comb begin : scan
		logic found;
		found = 1'b0;
		o = thread_pkg::FFO_NONE;
		for (int k = 0; k < thread_pkg::FFO_W; k++) begin
			if (!found && i[k]) begin
				o = 4'(k);
				found = 1'b1;
			end
		end
	end

endmodule

// File: design/sched_if.sv
// ==========================================================================
// Scheduling signals between the thread table, selector and credit counter
// One instance lives in the top level, each block takes its own modport
// ==========================================================================
`timescale 1ns/100ps

interface sched_if;

	// Threads that are ready to issue, one bit per thread
	logic [thread_pkg::NTHREADS-1:0] ready;

	// At least one downstream credit is held
	logic credit_ok;

	// Combinational grant from the selector
	logic grant_valid;
	thread_pkg::tid_t grant_tid;

	// The thread table publishes readiness and consumes the grant
	modport thread_table (output ready, input grant_valid, input grant_tid);

	// The selector turns readiness and credit into a grant
	modport select (input ready, input credit_ok, output grant_valid, output grant_tid);

	// The credit counter spends a credit on every grant
	modport credit (output credit_ok, input grant_valid);

endinterface

// File: design/round_robin_select.sv
// ==========================================================================
// Round-robin thread selector with a combinational grant
// Priority rotates by one thread position after every grant
// ==========================================================================
`timescale 1ns/100ps

module round_robin_select (
	input  logic    rst,
	input  logic    clk,
	sched_if.select sif
);

	// Eligible threads after the credit check
	logic [thread_pkg::NTHREADS-1:0] elig;

	// Eligible mask shifted into a double-width word
	logic [2*thread_pkg::NTHREADS-1:0] shifted;

	// Eligible mask rotated left by amt
	logic [thread_pkg::NTHREADS-1:0] rotated;

	// Encoder result on the rotated mask
	logic [3:0] ffo_idx;

	// Rotation amount, counts grants modulo NTHREADS
	thread_pkg::tid_t amt;

	// ======================================================================
	// Rotation and encode
	// ======================================================================

	// Without a credit no thread is eligible, so nobody loses readiness
	always_comb
		elig = sif.ready & {thread_pkg::NTHREADS{sif.credit_ok}};

	// Bit t lands at position t+amt, the overflow half folds back to the bottom
	always_comb
		shifted = {{thread_pkg::NTHREADS{1'b0}}, elig} << amt;

	always_comb
		rotated = shifted[2*thread_pkg::NTHREADS-1:thread_pkg::NTHREADS]
			| shifted[thread_pkg::NTHREADS-1:0];

	find_first_one find_first_one_inst (
		.i({{(thread_pkg::FFO_W - thread_pkg::NTHREADS){1'b0}}, rotated}),
		.o(ffo_idx)
	);

	// The none code doubles as the valid test
	assign sif.grant_valid = (ffo_idx != thread_pkg::FFO_NONE);

	// Undo the rotation, the 3-bit subtract wraps modulo NTHREADS
	assign sif.grant_tid = ffo_idx[thread_pkg::TID_W-1:0] - amt;

	// ======================================================================
	// Rotation state
	// ======================================================================

	// Advance once per grant and hold while nothing is granted
	always_ff @(posedge clk, posedge rst) begin
		if (rst)
			amt <= '0;
		else if (sif.grant_valid) begin
			if (amt == thread_pkg::tid_t'(thread_pkg::NTHREADS - 1))
				amt <= '0;
			else
				amt <= amt + 1'b1;
		end
	end

	// The undone rotation must point back at a thread the table marked ready
	a_grant_is_ready: assert property (
		@(posedge clk) disable iff (rst)
		sif.grant_valid |-> sif.ready[sif.grant_tid]
	);

endmodule

// File: design/thread_state_table.sv
// ==========================================================================
// Per-thread ready flags and program counters with the registered issue port
// Wake and redirect make a thread ready, a grant issues it and puts it to sleep
// ==========================================================================
`timescale 1ns/100ps

module thread_state_table (
	input  logic                            rst,
	input  logic                            clk,
	input  logic [thread_pkg::NTHREADS-1:0] wake,
	input  logic                            redirect_valid,
	input  thread_pkg::tid_t                redirect_tid,
	input  issue_pkg::pc_t                  redirect_pc,
	output logic                            issue_valid,
	output thread_pkg::tid_t                issue_tid,
	output issue_pkg::pc_t                  issue_pc,
	sched_if.thread_table                   sif
);

	// Ready flag per thread
	logic [thread_pkg::NTHREADS-1:0] ready_q;

	// Next ready flags after grant, wake and redirect
	logic [thread_pkg::NTHREADS-1:0] ready_nxt;

	// Program counter per thread
	issue_pkg::pc_t pc_q [thread_pkg::NTHREADS];

	assign sif.ready = ready_q;

	// ======================================================================
	// Ready flags
	// ======================================================================

	// The grant clears first so a wake or redirect on the same edge wins
	always_comb begin
		ready_nxt = ready_q;
		if (sif.grant_valid)
			ready_nxt[sif.grant_tid] = 1'b0;
		ready_nxt = ready_nxt | wake;
		if (redirect_valid)
			ready_nxt[redirect_tid] = 1'b1;
	end

	always_ff @(posedge clk, posedge rst) begin
		if (rst)
			ready_q <= '0;
		else
			ready_q <= ready_nxt;
	end

	// ======================================================================
	// Program counters
	// ======================================================================

	// A redirect overrides the post-issue increment on the same thread
	always_ff @(posedge clk, posedge rst) begin
		if (rst) begin
			for (int t = 0; t < thread_pkg::NTHREADS; t++)
				pc_q[t] <= '0;
		end
		else begin
			for (int t = 0; t < thread_pkg::NTHREADS; t++) begin
				if (redirect_valid && redirect_tid == thread_pkg::tid_t'(t))
					pc_q[t] <= redirect_pc;
				else if (sif.grant_valid && sif.grant_tid == thread_pkg::tid_t'(t))
					pc_q[t] <= pc_q[t] + issue_pkg::pc_t'(4);
			end
		end
	end

	// ======================================================================
	// Issue port
	// ======================================================================

	// One-cycle pulse per grant
	always_ff @(posedge clk, posedge rst) begin
		if (rst)
			issue_valid <= 1'b0;
		else
			issue_valid <= sif.grant_valid;
	end

	// Payload carries the PC as it stood before the increment
	always_ff @(posedge clk) begin
		if (sif.grant_valid) begin
			issue_tid <= sif.grant_tid;
			issue_pc <= pc_q[sif.grant_tid];
		end
	end

	// The selector may only grant out of a non-empty ready mask
	a_no_grant_idle: assert property (
		@(posedge clk) disable iff (rst)
		sif.grant_valid |-> (|ready_q)
	);

endmodule

// File: design/issue_credit_counter.sv
// ==========================================================================
// Credit counter for the downstream pipeline
// Spends one credit per grant and recovers one per credit_return pulse
// ==========================================================================
`timescale 1ns/100ps

module issue_credit_counter (
	input  logic    rst,
	input  logic    clk,
	input  logic    credit_return,
	sched_if.credit sif
);

	// Credits currently held
	logic [issue_pkg::CREDIT_W-1:0] count;

	// A grant and a return in the same cycle cancel out
	always_ff @(posedge clk, posedge rst) begin
		if (rst)
			count <= issue_pkg::CREDITS;
		else begin
			case ({sif.grant_valid, credit_return})
				2'b10: count <= count - 1'b1;
				2'b01: count <= count + 1'b1;
				default: count <= count;
			endcase
		end
	end

	// Straight from the register, so a returned credit is usable next cycle
	assign sif.credit_ok = (count != '0);

	// ======================================================================
	// Checks
	// ======================================================================

	// Returns may never outnumber the issues still outstanding
	a_count_max: assert property (
		@(posedge clk) disable iff (rst)
		count <= issue_pkg::CREDITS
	);

	// An empty counter must hold the selector off
	a_no_grant_empty: assert property (
		@(posedge clk) disable iff (rst)
		(count == '0) |-> !sif.grant_valid
	);

endmodule

// File: design/thread_issue_top.sv
// ==========================================================================
// Thread issue scheduler top level with plain ports
// Joins the thread table, round-robin selector and credit counter
// ==========================================================================
`timescale 1ns/100ps

module thread_issue_top (
	input  logic                            clk,
	input  logic                            rst,
	input  logic [thread_pkg::NTHREADS-1:0] wake,
	input  logic                            redirect_valid,
	input  thread_pkg::tid_t                redirect_tid,
	input  issue_pkg::pc_t                  redirect_pc,
	input  logic                            credit_return,
	output logic                            issue_valid,
	output thread_pkg::tid_t                issue_tid,
	output issue_pkg::pc_t                  issue_pc
);

	// Shared scheduling signals
	sched_if sched ();

	// Picks one ready thread per cycle while credits remain
	round_robin_select round_robin_select_inst (
		.rst(rst),
		.clk(clk),
		.sif(sched.select)
	);

	// Holds thread state and drives the issue port
	thread_state_table thread_state_table_inst (
		.rst(rst),
		.clk(clk),
		.wake(wake),
		.redirect_valid(redirect_valid),
		.redirect_tid(redirect_tid),
		.redirect_pc(redirect_pc),
		.issue_valid(issue_valid),
		.issue_tid(issue_tid),
		.issue_pc(issue_pc),
		.sif(sched.thread_table)
	);

	// Tracks credits granted by the pipeline
	issue_credit_counter issue_credit_counter_inst (
		.rst(rst),
		.clk(clk),
		.credit_return(credit_return),
		.sif(sched.credit)
	);

endmodule

// File: testbench/thread_issue_tb.sv
// ==========================================================================
// Testbench for the thread issue scheduler, checked against a reference model
// Runs directed phases and a random phase and compares every issue cycle
// ==========================================================================
`timescale 1ns/100ps

module thread_issue_tb;

	logic                            clk;
	logic                            rst;
	logic [thread_pkg::NTHREADS-1:0] wake;
	logic                            redirect_valid;
	thread_pkg::tid_t                redirect_tid;
	issue_pkg::pc_t                  redirect_pc;
	logic                            credit_return;
	logic                            issue_valid;
	thread_pkg::tid_t                issue_tid;
	issue_pkg::pc_t                  issue_pc;

	// Reference model state, updated once per rising edge
	logic [thread_pkg::NTHREADS-1:0] m_ready;
	issue_pkg::pc_t                  m_pc [thread_pkg::NTHREADS];
	thread_pkg::tid_t                m_amt;
	int                              m_credits;

	// Issue the model expects on the port after the latest edge
	bit                              exp_valid;
	thread_pkg::tid_t                exp_tid;
	issue_pkg::pc_t                  exp_pc;

	// Payload of the latest issue seen on the port
	thread_pkg::tid_t                seen_tid;
	issue_pkg::pc_t                  seen_pc;

	bit                              checking;
	int                              issue_count;
	int                              mismatches;
	int                              timeouts;
	int                              base;
	integer                          seed;

	thread_issue_top thread_issue_top_inst (
		.clk(clk),
		.rst(rst),
		.wake(wake),
		.redirect_valid(redirect_valid),
		.redirect_tid(redirect_tid),
		.redirect_pc(redirect_pc),
		.credit_return(credit_return),
		.issue_valid(issue_valid),
		.issue_tid(issue_tid),
		.issue_pc(issue_pc)
	);

	initial begin
		clk = 1'b0;
		forever #50 clk = ~clk;
	end

	// ======================================================================
	// Reference model
	// ======================================================================

	// The ready thread with the lowest (t + amt) mod NTHREADS wins, only with a credit
	function automatic bit predict_grant(input logic [thread_pkg::NTHREADS-1:0] rdy,
		input thread_pkg::tid_t amt, input int credits, output thread_pkg::tid_t tid);
		int best;
		int key;
		best = thread_pkg::NTHREADS;
		tid = '0;
		if (credits == 0)
			return 1'b0;
		for (int t = 0; t < thread_pkg::NTHREADS; t++) begin
			key = (t + int'(amt)) % thread_pkg::NTHREADS;
			if (rdy[t] && key < best) begin
				best = key;
				tid = thread_pkg::tid_t'(t);
			end
		end
		return best < thread_pkg::NTHREADS;
	endfunction

	// ======================================================================
	// Compare tasks
	// ======================================================================

	task automatic check_valid(input logic got, input bit exp);
		if (got !== exp) begin
			$display("FAILED at %0t: issue_valid is %b, expected %b", $time, got, exp);
			mismatches++;
		end
	endtask

	task automatic check_tid(input thread_pkg::tid_t got, input thread_pkg::tid_t exp);
		if (got !== exp) begin
			$display("FAILED at %0t: issue_tid is %0d, expected %0d", $time, got, exp);
			mismatches++;
		end
	endtask

	task automatic check_pc(input issue_pkg::pc_t got, input issue_pkg::pc_t exp);
		if (got !== exp) begin
			$display("FAILED at %0t: issue_pc is %h, expected %h", $time, got, exp);
			mismatches++;
		end
	endtask

	task automatic check_issues(input int got, input int exp, input string what);
		if (got != exp) begin
			$display("FAILED at %0t: %s counted %0d, expected %0d", $time, what, got, exp);
			mismatches++;
		end
	endtask

	// Outputs settle after the rising edge, so compare on the falling edge
	always @(negedge clk) begin
		if (checking) begin
			check_valid(issue_valid, exp_valid);
			if (exp_valid && issue_valid === 1'b1) begin
				check_tid(issue_tid, exp_tid);
				check_pc(issue_pc, exp_pc);
			end
			if (issue_valid === 1'b1) begin
				issue_count++;
				seen_tid = issue_tid;
				seen_pc = issue_pc;
			end
		end
	end

	// ======================================================================
	// Stimulus
	// ======================================================================

	// Advance the model over one edge with the inputs the DUT samples there,
	// then drive the next inputs
	task automatic step(input logic [thread_pkg::NTHREADS-1:0] wake_req, input bit rv,
		input thread_pkg::tid_t rtid, input issue_pkg::pc_t rpc, input bit cret_req,
		input bit hit_grant);
		thread_pkg::tid_t g_tid;
		bit g;
		logic [thread_pkg::NTHREADS-1:0] w;
		@(posedge clk);
		g = predict_grant(m_ready, m_amt, m_credits, g_tid);
		exp_valid = g;
		if (g) begin
			exp_tid = g_tid;
			exp_pc = m_pc[g_tid];
			m_ready[g_tid] = 1'b0;
			m_pc[g_tid] = m_pc[g_tid] + 32'd4;
			m_amt = thread_pkg::tid_t'((int'(m_amt) + 1) % thread_pkg::NTHREADS);
			m_credits--;
		end
		// Setting a ready bit wins over the grant's clear on the same edge
		m_ready = m_ready | wake;
		if (redirect_valid) begin
			m_ready[redirect_tid] = 1'b1;
			m_pc[redirect_tid] = redirect_pc;
		end
		if (credit_return)
			m_credits++;
		w = wake_req;
		// Wake the thread that will be granted at the next edge
		if (hit_grant && predict_grant(m_ready, m_amt, m_credits, g_tid))
			w[g_tid] = 1'b1;
		wake <= w;
		redirect_valid <= rv;
		redirect_tid <= rtid;
		redirect_pc <= rpc;
		// Never hand back more credits than are outstanding
		credit_return <= cret_req && (m_credits < int'(issue_pkg::CREDITS));
	endtask

	task automatic idle_cycles(input int n, input bit cret);
		for (int k = 0; k < n; k++)
			step('0, 1'b0, '0, '0, cret, 1'b0);
	endtask

	task automatic wait_issue(input int limit);
		int start;
		int n;
		start = issue_count;
		n = 0;
		while (issue_count == start && n < limit) begin
			step('0, 1'b0, '0, '0, 1'b1, 1'b0);
			n++;
		end
		if (issue_count == start) begin
			$display("Timeout at %0t: no issue within %0d cycles", $time, limit);
			timeouts++;
		end
	endtask

	// Issue every ready thread and refill the credits
	task automatic drain(input int limit);
		int n;
		n = 0;
		while ((m_ready != '0 || m_credits != int'(issue_pkg::CREDITS)) && n < limit) begin
			step('0, 1'b0, '0, '0, 1'b1, 1'b0);
			n++;
		end
		if (m_ready != '0 || m_credits != int'(issue_pkg::CREDITS)) begin
			$display("Timeout at %0t: threads and credits did not drain", $time);
			timeouts++;
		end
	endtask

	task automatic random_cycle();
		logic [thread_pkg::NTHREADS-1:0] w;
		bit rv;
		thread_pkg::tid_t rtid;
		issue_pkg::pc_t rpc;
		bit cret;
		bit hit;
		integer r;
		r = $random(seed) & $random(seed) & $random(seed);
		w = r[thread_pkg::NTHREADS-1:0];
		rv = ($random(seed) & 7) == 0;
		r = $random(seed);
		rtid = r[thread_pkg::TID_W-1:0];
		rpc = $random(seed) & ~32'h3;
		r = $random(seed);
		cret = r[0];
		hit = ($random(seed) & 3) == 0;
		step(w, rv, rtid, rpc, cret, hit);
	endtask

	initial begin
		seed = 32'h74b5_05cc;
		rst = 1'b1;
		wake = '0;
		redirect_valid = 1'b0;
		redirect_tid = '0;
		redirect_pc = '0;
		credit_return = 1'b0;
		m_ready = '0;
		for (int t = 0; t < thread_pkg::NTHREADS; t++)
			m_pc[t] = '0;
		m_amt = '0;
		m_credits = int'(issue_pkg::CREDITS);
		exp_valid = 1'b0;
		exp_tid = '0;
		exp_pc = '0;
		seen_tid = '0;
		seen_pc = '0;
		checking = 1'b0;
		issue_count = 0;
		mismatches = 0;
		timeouts = 0;
		repeat (4) @(posedge clk);
		rst <= 1'b0;
		checking = 1'b1;

		// Quiet after reset, then a redirect issues its PC and a wake the next one
		base = issue_count;
		idle_cycles(6, 1'b0);
		check_issues(issue_count - base, 0, "issues before any redirect");
		step('0, 1'b1, 3'd5, 32'h0000_1000, 1'b0, 1'b0);
		wait_issue(10);
		check_tid(seen_tid, 3'd5);
		check_pc(seen_pc, 32'h0000_1000);
		step(8'h20, 1'b0, '0, '0, 1'b0, 1'b0);
		wait_issue(10);
		check_tid(seen_tid, 3'd5);
		check_pc(seen_pc, 32'h0000_1004);
		drain(20);

		// With all threads woken at once the credit returns keep issues back to back
		base = issue_count;
		step('1, 1'b0, '0, '0, 1'b1, 1'b0);
		idle_cycles(10, 1'b1);
		check_issues(issue_count - base, 8, "back-to-back issues");
		drain(20);

		// No returns, so only the reset credits can be spent
		base = issue_count;
		step('1, 1'b0, '0, '0, 1'b0, 1'b0);
		idle_cycles(12, 1'b0);
		check_issues(issue_count - base, int'(issue_pkg::CREDITS), "issues without returns");
		for (int k = 0; k < 4; k++) begin
			base = issue_count;
			idle_cycles(1, 1'b1);
			idle_cycles(5, 1'b0);
			check_issues(issue_count - base, 1, "issues per returned credit");
		end
		drain(40);

		// Random wakes, redirects and returns
		for (int c = 0; c < 2000; c++)
			random_cycle();
		drain(80);
		idle_cycles(2, 1'b0);

		$display("Errors: %0d mismatches, %0d timeouts, %0d issues seen",
			mismatches, timeouts, issue_count);
		if (mismatches == 0 && timeouts == 0)
			$display("Simulation finished: PASS");
		else
			$display("Simulation finished: FAIL");
		$finish;
	end

endmodule

// File: thread_issue.f
design/thread_pkg.sv
design/issue_pkg.sv
design/find_first_one.sv
design/sched_if.sv
design/round_robin_select.sv
design/thread_state_table.sv
design/issue_credit_counter.sv
design/thread_issue_top.sv
testbench/thread_issue_tb.sv
